//--- capture/ccdCapture.sv
`timescale 1ns/1ps
`default_nettype none

module ccdCapture import cameraPkg::*;
(
	input  logic                       D5M_PIXLCLK,
	input  logic                       rstN,
	input  logic [pixelWidth-1:0]      pixData,
	input  logic                       frameValid,
	input  logic                       lineValid,
	input  logic                       startCapture,
	input  logic                       stopCapture,
	output logic [pixelWidth-1:0]      rawData,
	output logic                       rawValid,
	output logic [countWidth-1:0]      xCount,
	output logic [countWidth-1:0]      yCount,
	output logic [frameCountWidth-1:0] frameCount
);

	// Registered sensor bus
	logic [pixelWidth-1:0] pixReg;
	logic                  fvReg;
	logic                  lvReg;
	logic                  fvPrev;
	logic                  lvPrev;

	// Capture state
	logic runFlag;
	logic captureFlag;

	// Position of the next sample
	logic [countWidth-1:0] colCount;
	logic [countWidth-1:0] rowCount;

	logic frameRise;
	logic frameFall;
	logic frameStart;
	logic frameActive;
	logic sampleValid;
	logic lineEnd;

	//======================================================================
	// Input registers
	//======================================================================

	// Sensor sample register
	always_ff @(posedge D5M_PIXLCLK)
	begin
		pixReg <= pixData;
	end

	always_ff @(posedge D5M_PIXLCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			fvReg  <= 1'b0;
			lvReg  <= 1'b0;
			fvPrev <= 1'b0;
			lvPrev <= 1'b0;
		end
		else
		begin
			fvReg  <= frameValid;
			lvReg  <= lineValid;
			fvPrev <= fvReg;
			lvPrev <= lvReg;
		end
	end

	assign frameRise  = fvReg && !fvPrev;
	assign frameFall  = !fvReg && fvPrev;
	assign frameStart = frameRise && runFlag;

	// A frame is captured from its very first sample
	assign frameActive = frameRise ? runFlag : captureFlag;
	assign sampleValid = frameActive && fvReg && lvReg;
	assign lineEnd     = captureFlag && lvPrev && !lvReg;

	//======================================================================
	// Start/stop gating and counters
	//======================================================================

	always_ff @(posedge D5M_PIXLCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			runFlag     <= 1'b0;
			captureFlag <= 1'b0;
			frameCount  <= '0;
		end
		else
		begin
			// Stop wins over start
			if (stopCapture)
				runFlag <= 1'b0;
			else if (startCapture)
				runFlag <= 1'b1;

			// Running frame always completes
			if (frameRise)
				captureFlag <= runFlag;
			else if (frameFall)
				captureFlag <= 1'b0;

			if (frameStart)
				frameCount <= frameCount + 1'b1;
		end
	end

	always_ff @(posedge D5M_PIXLCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			rawValid <= 1'b0;
			xCount   <= '0;
			yCount   <= '0;
			colCount <= '0;
			rowCount <= '0;
		end
		else
		begin
			rawValid <= sampleValid;
			if (sampleValid)
			begin
				xCount <= frameStart ? '0 : colCount;
				yCount <= frameStart ? '0 : rowCount;
			end

			if (frameStart)
			begin
				colCount <= sampleValid ? countWidth'(1) : '0;
				rowCount <= '0;
			end
			else if (sampleValid)
				colCount <= colCount + 1'b1;
			else if (lineEnd)
			begin
				colCount <= '0;
				rowCount <= rowCount + 1'b1;
			end
		end
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (sampleValid)
			rawData <= pixReg;
	end

endmodule

`default_nettype wire

//--- common/cameraPkg.sv
`default_nettype none

package cameraPkg;

	//======================================================================
	// Sensor and pipeline widths
	//======================================================================

	// One raw sample and one colour channel
	localparam int pixelWidth      = 12;
	localparam int countWidth      = 16;
	localparam int frameCountWidth = 32;

	// Longest active line the line buffer can hold
	localparam int maxLineWidth  = 1280;
	localparam int lineAddrWidth = $clog2(maxLineWidth);

	// Grey level at or above which a pixel turns white
	localparam int binaryThreshold = 2048;

	//======================================================================
	// Frame-buffer word layout
	//======================================================================

	localparam int fbChannelBits = 10;
	localparam int fbGreenBits   = 5;

	// Upper green half with blue
	typedef struct packed {
		logic                     pad;
		logic [fbGreenBits-1:0]   greenHi;
		logic [fbChannelBits-1:0] blue;
	} fbHiView_s;

	// Lower green half with red
	typedef struct packed {
		logic                     pad;
		logic [fbGreenBits-1:0]   greenLo;
		logic [fbChannelBits-1:0] red;
	} fbLoView_s;

	typedef union packed {
		fbHiView_s hiView;
		fbLoView_s loView;
	} fbWord_u;

endpackage

`default_nettype wire

//--- demosaic/raw2Rgb.sv
`timescale 1ns/1ps
`default_nettype none

module raw2Rgb import cameraPkg::*;
(
	input  logic                  D5M_PIXLCLK,
	input  logic                  rstN,
	input  logic [pixelWidth-1:0] rawData,
	input  logic                  rawValid,
	input  logic [countWidth-1:0] xCount,
	input  logic [countWidth-1:0] yCount,
	output logic [pixelWidth-1:0] red,
	output logic [pixelWidth-1:0] green,
	output logic [pixelWidth-1:0] blue,
	output logic                  rgbValid
);

	//======================================================================
	// Line buffer
	//======================================================================

	// Holds the last even row (green, red, green, red ...)
	logic [pixelWidth-1:0] lineBuf [maxLineWidth];

	// Previous sample of the row being received
	logic [pixelWidth-1:0] prevSample;

	logic [lineAddrWidth-1:0] colAddr;
	logic [lineAddrWidth-1:0] pairAddr;
	logic                     evenRow;
	logic                     blockDone;

	logic [pixelWidth-1:0] bufRed;
	logic [pixelWidth-1:0] bufGreen;
	logic [pixelWidth:0]   greenSum;

	assign colAddr  = xCount[lineAddrWidth-1:0];

	// Left column of the 2x2 block
	assign pairAddr = {colAddr[lineAddrWidth-1:1], 1'b0};

	assign evenRow   = !yCount[0];
	assign blockDone = rawValid && yCount[0] && xCount[0];

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rawValid && evenRow)
			lineBuf[colAddr] <= rawData;
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rawValid)
			prevSample <= rawData;
	end

	//======================================================================
	// Bayer block to RGB
	//======================================================================

	// Upper row of the block, from the buffer
	assign bufRed   = lineBuf[colAddr];
	assign bufGreen = lineBuf[pairAddr];

	// Two greens on the diagonal, averaged
	assign greenSum = {1'b0, bufGreen} + {1'b0, rawData};

	always_ff @(posedge D5M_PIXLCLK or negedge rstN)
	begin
		if (!rstN)
			rgbValid <= 1'b0;
		else
			rgbValid <= blockDone;
	end

	// Colour outputs only change on a finished block
	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (blockDone)
		begin
			red   <= bufRed;
			green <= greenSum[pixelWidth:1];
			blue  <= prevSample;
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the pixel pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module tbPixelPipe \
	--Mdir obj_dir -o simPixelPipe > build.log 2>&1 \
	&& ./obj_dir/simPixelPipe > sim.log 2>&1 \
	&& cat sim.log \
	&& grep -qx "Regression passed" sim.log \
	&& echo "Simulation PASS" \
	|| { cat build.log sim.log 2>/dev/null; echo "Simulation FAIL"; exit 1; }

//--- source/pixelPipe.sv
`timescale 1ns/1ps
`default_nettype none

module pixelPipe import cameraPkg::*;
(
	input  logic                       D5M_PIXLCLK,
	input  logic                       rstN,
	input  logic [pixelWidth-1:0]      pixData,
	input  logic                       frameValid,
	input  logic                       lineValid,
	input  logic                       startCapture,
	input  logic                       stopCapture,
	input  logic                       grayMode,
	input  logic                       binaryMode,
	output logic                       fbValid,
	output fbWord_u                    fbWordHi,
	output fbWord_u                    fbWordLo,
	output logic [frameCountWidth-1:0] frameCount
);

	// Capture to demosaic
	logic [pixelWidth-1:0] rawData;
	logic                  rawValid;
	logic [countWidth-1:0] xCount;
	logic [countWidth-1:0] yCount;

	// Demosaic to tone map
	logic [pixelWidth-1:0] red;
	logic [pixelWidth-1:0] green;
	logic [pixelWidth-1:0] blue;
	logic                  rgbValid;

	//======================================================================
	// Pipeline stages
	//======================================================================

	ccdCapture capture (
		.D5M_PIXLCLK  (D5M_PIXLCLK),
		.rstN         (rstN),
		.pixData      (pixData),
		.frameValid   (frameValid),
		.lineValid    (lineValid),
		.startCapture (startCapture),
		.stopCapture  (stopCapture),
		.rawData      (rawData),
		.rawValid     (rawValid),
		.xCount       (xCount),
		.yCount       (yCount),
		.frameCount   (frameCount)
	);

	raw2Rgb demosaic (
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.rstN        (rstN),
		.rawData     (rawData),
		.rawValid    (rawValid),
		.xCount      (xCount),
		.yCount      (yCount),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.rgbValid    (rgbValid)
	);

	toneMap tone (
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.rstN        (rstN),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.rgbValid    (rgbValid),
		.grayMode    (grayMode),
		.binaryMode  (binaryMode),
		.fbValid     (fbValid),
		.fbWordHi    (fbWordHi),
		.fbWordLo    (fbWordLo)
	);

endmodule

`default_nettype wire

//--- source/toneMap.sv
`timescale 1ns/1ps
`default_nettype none

module toneMap import cameraPkg::*;
(
	input  logic                  D5M_PIXLCLK,
	input  logic                  rstN,
	input  logic [pixelWidth-1:0] red,
	input  logic [pixelWidth-1:0] green,
	input  logic [pixelWidth-1:0] blue,
	input  logic                  rgbValid,
	input  logic                  grayMode,
	input  logic                  binaryMode,
	output logic                  fbValid,
	output fbWord_u               fbWordHi,
	output fbWord_u               fbWordLo
);

	// Stage one
	logic [pixelWidth-1:0] redReg;
	logic [pixelWidth-1:0] greenReg;
	logic [pixelWidth-1:0] blueReg;
	logic [pixelWidth-1:0] greyReg;
	logic                  stageValid;

	logic [pixelWidth+1:0] greySum;

	// Stage two selection
	logic [pixelWidth-1:0] binPix;
	logic [pixelWidth-1:0] outRed;
	logic [pixelWidth-1:0] outGreen;
	logic [pixelWidth-1:0] outBlue;
	fbWord_u               hiNext;
	fbWord_u               loNext;

	// R + 2G + B, then divide by four
	assign greySum = {2'b00, red} + {1'b0, green, 1'b0} + {2'b00, blue};

	always_ff @(posedge D5M_PIXLCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			stageValid <= 1'b0;
			fbValid    <= 1'b0;
		end
		else
		begin
			stageValid <= rgbValid;
			fbValid    <= stageValid;
		end
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		redReg   <= red;
		greenReg <= green;
		blueReg  <= blue;
		greyReg  <= greySum[pixelWidth+1:2];
	end

	//======================================================================
	// Mode select and frame-buffer packing
	//======================================================================

	assign binPix = (greyReg >= pixelWidth'(binaryThreshold)) ? '1 : '0;

	always_comb
	begin
		if (binaryMode)
		begin
			outRed   = binPix;
			outGreen = binPix;
			outBlue  = binPix;
		end
		else if (grayMode)
		begin
			outRed   = greyReg;
			outGreen = greyReg;
			outBlue  = greyReg;
		end
		else
		begin
			outRed   = redReg;
			outGreen = greenReg;
			outBlue  = blueReg;
		end

		// Green top bits split over the two words
		hiNext.hiView.pad     = 1'b0;
		hiNext.hiView.greenHi = outGreen[pixelWidth-1 -: fbGreenBits];
		hiNext.hiView.blue    = outBlue[pixelWidth-1 -: fbChannelBits];
		loNext.loView.pad     = 1'b0;
		loNext.loView.greenLo = outGreen[pixelWidth-1-fbGreenBits -: fbGreenBits];
		loNext.loView.red     = outRed[pixelWidth-1 -: fbChannelBits];
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		fbWordHi <= hiNext;
		fbWordLo <= loNext;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+test
common/cameraPkg.sv
capture/ccdCapture.sv
demosaic/raw2Rgb.sv
source/toneMap.sv
source/pixelPipe.sv
test/tbPixelPipe.sv

//--- test/pipeModel.svh
`ifndef PIPE_MODEL_SVH
`define PIPE_MODEL_SVH

//======================================================================
// Reference model of the pixel pipeline
//======================================================================

// Samples of the frame being generated
logic [pixelWidth-1:0] frameSamples [activeLines][activeCols];

// Expected word pairs, oldest first
fbWord_u expHi [$];
fbWord_u expLo [$];

// One 2x2 Bayer block to an output pixel, mode rules applied
function automatic void refPixel(input int by, input int bx, input bit gray, input bit binary,
		output int r, output int g, output int b);
	int grey;
	int full;
	full = (1 << pixelWidth) - 1;
	r = int'(frameSamples[2*by][2*bx+1]);
	b = int'(frameSamples[2*by+1][2*bx]);
	// Diagonal greens averaged, truncated
	g = (int'(frameSamples[2*by][2*bx]) + int'(frameSamples[2*by+1][2*bx+1])) / 2;
	grey = (r + 2 * g + b) / 4;
	if (binary)
	begin
		r = (grey >= binaryThreshold) ? full : 0;
		g = r;
		b = r;
	end
	else if (gray)
	begin
		r = grey;
		g = grey;
		b = grey;
	end
endfunction

// Upper green bits with blue
function automatic fbWord_u packHi(input int g, input int b);
	fbWord_u w;
	w = '0;
	w.hiView.greenHi = fbGreenBits'(g >> (pixelWidth - fbGreenBits));
	w.hiView.blue    = fbChannelBits'(b >> (pixelWidth - fbChannelBits));
	return w;
endfunction

// Lower green bits with red
function automatic fbWord_u packLo(input int g, input int r);
	fbWord_u w;
	w = '0;
	w.loView.greenLo = fbGreenBits'(g >> (pixelWidth - fbChannelBits));
	w.loView.red     = fbChannelBits'(r >> (pixelWidth - fbChannelBits));
	return w;
endfunction

// Blocks come out in raster order
function automatic void pushExpected(input bit gray, input bit binary);
	int r;
	int g;
	int b;
	for (int by = 0; by < activeLines / 2; by++)
	begin
		for (int bx = 0; bx < activeCols / 2; bx++)
		begin
			refPixel(by, bx, gray, binary, r, g, b);
			expHi.push_back(packHi(g, b));
			expLo.push_back(packLo(g, r));
		end
	end
endfunction

//======================================================================
// Compare tasks
//======================================================================

task automatic checkWord(input string name, input string field, input fbWord_u expWord,
		input fbWord_u actWord);
	if (actWord !== expWord)
	begin
		$display("ERR %s %s expected %h actual %h", name, field, expWord, actWord);
		testErrors++;
	end
endtask

task automatic checkCount(input string name, input logic [frameCountWidth-1:0] expCount,
		input logic [frameCountWidth-1:0] actCount);
	if (actCount !== expCount)
	begin
		$display("ERR %s frameCount expected %0d actual %0d", name, expCount, actCount);
		testErrors++;
	end
endtask

`endif

//--- test/tbPixelPipe.sv
`timescale 1ns/1ps
`default_nettype none

module tbPixelPipe import cameraPkg::*;
();

	// Generated frame geometry
	localparam int activeCols  = 8;
	localparam int activeLines = 6;
	localparam int lineBlank   = 4;
	localparam int frameBlank  = 10;
	localparam int frameCycles = activeLines * (activeCols + lineBlank) + frameBlank;
	localparam int numFrames   = 8;
	localparam int timeoutCycles = 2 * numFrames * frameCycles + 100;

	logic                       D5M_PIXLCLK = 1'b0;
	logic                       rstN;
	logic [pixelWidth-1:0]      pixData;
	logic                       frameValid;
	logic                       lineValid;
	logic                       startCapture;
	logic                       stopCapture;
	logic                       grayMode;
	logic                       binaryMode;
	logic                       fbValid;
	fbWord_u                    fbWordHi;
	fbWord_u                    fbWordLo;
	logic [frameCountWidth-1:0] frameCount;

	integer seed;
	int     cycleCount = 0;
	string  testName;
	int     testErrors;
	int     totalErrors;
	int     testsRun;
	int     testsFailed;
	int     pairsSeen;
	int     expFrames;
	fbWord_u hiExpWord;
	fbWord_u loExpWord;

	`include "pipeModel.svh"

	pixelPipe uut (
		.D5M_PIXLCLK  (D5M_PIXLCLK),
		.rstN         (rstN),
		.pixData      (pixData),
		.frameValid   (frameValid),
		.lineValid    (lineValid),
		.startCapture (startCapture),
		.stopCapture  (stopCapture),
		.grayMode     (grayMode),
		.binaryMode   (binaryMode),
		.fbValid      (fbValid),
		.fbWordHi     (fbWordHi),
		.fbWordLo     (fbWordLo),
		.frameCount   (frameCount)
	);

	always #100 D5M_PIXLCLK = ~D5M_PIXLCLK;

	//======================================================================
	// Stimulus helpers
	//======================================================================

	function automatic logic [pixelWidth-1:0] randomPix();
		return pixelWidth'($random(seed));
	endfunction

	task automatic setControls(input bit start, input bit stop, input bit gray, input bit binary);
		@(posedge D5M_PIXLCLK);
		startCapture <= start;
		stopCapture  <= stop;
		grayMode     <= gray;
		binaryMode   <= binary;
		@(negedge D5M_PIXLCLK);
	endtask

	// One frame; stop is raised in the blanking after line stopLine
	task automatic runFrame(input bit captured, input int stopLine);
		for (int row = 0; row < activeLines; row++)
			for (int col = 0; col < activeCols; col++)
				frameSamples[row][col] = randomPix();
		if (captured)
		begin
			pushExpected(grayMode, binaryMode);
			expFrames++;
		end
		for (int row = 0; row < activeLines; row++)
		begin
			for (int col = 0; col < activeCols; col++)
			begin
				@(posedge D5M_PIXLCLK);
				frameValid <= 1'b1;
				lineValid  <= 1'b1;
				pixData    <= frameSamples[row][col];
			end
			for (int blank = 0; blank < lineBlank; blank++)
			begin
				@(posedge D5M_PIXLCLK);
				lineValid <= 1'b0;
				pixData   <= randomPix();
				if (row == stopLine && blank == 0)
				begin
					stopCapture  <= 1'b1;
					startCapture <= 1'b0;
				end
			end
		end
		for (int blank = 0; blank < frameBlank; blank++)
		begin
			@(posedge D5M_PIXLCLK);
			frameValid <= 1'b0;
			lineValid  <= 1'b0;
			pixData    <= randomPix();
		end
	endtask

	task automatic beginTest(input string name);
		testName   = name;
		testErrors = 0;
		pairsSeen  = 0;
	endtask

	task automatic finishTest(input int expPairs);
		@(negedge D5M_PIXLCLK);
		while (expHi.size() != 0)
			@(negedge D5M_PIXLCLK);
		if (pairsSeen != expPairs)
		begin
			$display("%s: saw %0d word pairs where %0d were due", testName, pairsSeen, expPairs);
			testErrors++;
		end
		checkCount(testName, expFrames, frameCount);
		$display("test %-12s %0d pairs, %0d errors", testName, pairsSeen, testErrors);
		testsRun++;
		if (testErrors != 0)
			testsFailed++;
		totalErrors += testErrors;
	endtask

	// Grey and binary words carry one value in all three fields
	task automatic checkModeFields(input fbWord_u hiAct, input fbWord_u loAct);
		logic [fbChannelBits-1:0] greenAct;
		greenAct = {hiAct.hiView.greenHi, loAct.loView.greenLo};
		if ((grayMode || binaryMode) &&
			!(greenAct == loAct.loView.red && hiAct.hiView.blue == loAct.loView.red))
		begin
			$display("%s: channel fields of a grey word pair differ", testName);
			testErrors++;
		end
		if (binaryMode && loAct.loView.red != '0 && loAct.loView.red != '1)
		begin
			$display("%s: binary field is neither all ones nor all zeros", testName);
			testErrors++;
		end
	endtask

	//======================================================================
	// Scoreboard and timeout
	//======================================================================

	always @(negedge D5M_PIXLCLK)
	begin
		if (rstN && fbValid)
		begin
			pairsSeen++;
			if (expHi.size() == 0)
			begin
				$display("%s: fbValid high with no word pair expected", testName);
				testErrors++;
			end
			else
			begin
				hiExpWord = expHi.pop_front();
				loExpWord = expLo.pop_front();
				checkWord(testName, "fbWordHi", hiExpWord, fbWordHi);
				checkWord(testName, "fbWordLo", loExpWord, fbWordLo);
				checkModeFields(fbWordHi, fbWordLo);
			end
		end
	end

	always @(posedge D5M_PIXLCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
			$display("Regression failed");
			$finish;
		end
	end

	//======================================================================
	// Test sequence
	//======================================================================

	initial
	begin
		seed         = 32'hfa9b953a;
		rstN         = 1'b0;
		pixData      = '0;
		frameValid   = 1'b0;
		lineValid    = 1'b0;
		startCapture = 1'b0;
		stopCapture  = 1'b0;
		grayMode     = 1'b0;
		binaryMode   = 1'b0;
		totalErrors  = 0;
		testsRun     = 0;
		testsFailed  = 0;
		expFrames    = 0;
		testName     = "reset";
		testErrors   = 0;
		pairsSeen    = 0;
		repeat (5) @(posedge D5M_PIXLCLK);
		rstN <= 1'b1;

		// No capture before start
		beginTest("idle");
		runFrame(1'b0, -1);
		finishTest(0);

		beginTest("colour");
		setControls(1'b1, 1'b0, 1'b0, 1'b0);
		runFrame(1'b1, -1);
		finishTest(12);

		beginTest("grey");
		setControls(1'b1, 1'b0, 1'b1, 1'b0);
		runFrame(1'b1, -1);
		finishTest(12);

		beginTest("binary");
		setControls(1'b1, 1'b0, 1'b0, 1'b1);
		runFrame(1'b1, -1);
		finishTest(12);

		// Binary wins over grey
		beginTest("binaryGrey");
		setControls(1'b1, 1'b0, 1'b1, 1'b1);
		runFrame(1'b1, -1);
		finishTest(12);

		// Stop mid frame, the frame still completes
		beginTest("stopFrame");
		setControls(1'b1, 1'b0, 1'b0, 1'b0);
		runFrame(1'b1, 2);
		finishTest(12);

		beginTest("afterStop");
		runFrame(1'b0, -1);
		finishTest(0);

		// Random data in every blank
		beginTest("blanking");
		setControls(1'b1, 1'b0, 1'b0, 1'b0);
		runFrame(1'b1, -1);
		finishTest(12);

		$display("Summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, totalErrors);
		if (testsFailed == 0 && totalErrors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
